//--- sim/clock_gen.sv
// ******************************
// testbench clock source
// ******************************

`timescale 1ns/1ns

`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_1MHz
);

    // starts low, first rising edge after half a period
    initial
    begin
        clk_1MHz = 1'b0;
        forever #(PERIOD_NS / 2) clk_1MHz = ~clk_1MHz;
    end

endmodule

`default_nettype wire

//--- sim/tb_sid_voice.sv
// ******************************
// sid_voice testbench
// lcg stimulus, voice model
// envelope timing checks, watchdog
// ******************************

`timescale 1ns/1ns

`default_nettype none

module tb_sid_voice;

    import osc_pkg::*;
    import env_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    // worst step spacing with rate nibbles 0..2
    localparam int ATTACK_WORST = 64;
    localparam int DR_WORST = 30;
    localparam int PLANNED_CYCLES = 3 + 200 + 256 * ATTACK_WORST + 600
                                    + 2 * 256 * DR_WORST + 400 + 200 + 2 * ATTACK_WORST;
    localparam int MARGIN_CYCLES = 2000;

    // reference divider reloads
    int attack_table [16] = '{8, 31, 63, 94, 150, 220, 268, 315,
                              394, 984, 1968, 3150, 3937, 11811, 19685, 31496};
    int dec_rel_table [16] = '{3, 15, 29, 44, 70, 103, 125, 147,
                               184, 459, 919, 1471, 1838, 5515, 9191, 14706};

    logic       clk_1MHz;
    logic       reset;
    freq_t      frequency;
    sample_t    pulse_width;
    wave_ctrl_t wave_ctrl;
    adsr_t      adsr;
    sample_t    voice;
    level_t     env_level;

    // model state
    phase_t  model_phase;
    sample_t model_sample;
    sample_t model_voice;
    // sample that fed the current voice
    sample_t voice_source;
    // level times 16 seen one cycle back
    sample_t prev_clamp;

    int unsigned lcg_state = 29403;
    int cycle;
    int checks;
    int value_errors;
    int other_errors;
    int atk_nib;
    int dcy_nib;
    int rel_nib;
    int sus_nib;
    int waited;

    clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk_1MHz(clk_1MHz));

    sid_voice u_dut (
        .clk_1MHz    (clk_1MHz),
        .reset       (reset),
        .frequency   (frequency),
        .pulse_width (pulse_width),
        .wave_ctrl   (wave_ctrl),
        .adsr        (adsr),
        .voice       (voice),
        .env_level   (env_level)
    );

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // low lcg bits repeat quickly
        return lcg_state >> 8;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % (hi - lo + 1));
    endfunction

    // waveform rules straight from the voice description
    function automatic sample_t model_mix(input phase_t ph, input sample_t pw,
                                          input wave_ctrl_t ctrl);
        sample_t saw;
        sample_t tri_w;
        sample_t pls;
        sample_t mix;
        saw = ph[23:12];
        tri_w = 12'hfff - (ph[22:11] ^ {12{ph[23]}});
        pls = (saw >= pw) ? 12'hfff : 12'h000;
        mix = '0;
        if (ctrl.sawtooth_en)
            mix = mix | saw;
        if (ctrl.triangle_en)
            mix = mix | tri_w;
        if (ctrl.pulse_en)
            mix = mix | pls;
        return mix;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            value_errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, expected, actual, cycle);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("failure at cycle %0d: %s", cycle, what);
    endtask

    // new pitch, width and enables, gate as given
    task automatic randomize_wave(input logic gate);
        int unsigned enables;
        enables = next_rand();
        frequency = freq_t'(next_rand());
        pulse_width = sample_t'(next_rand());
        wave_ctrl.gate = gate;
        wave_ctrl.triangle_en = enables[0];
        wave_ctrl.sawtooth_en = enables[1];
        wave_ctrl.pulse_en = enables[2];
    endtask

    // one clock, then step the model with the inputs of that edge
    task automatic advance();
        @(negedge clk_1MHz);
        cycle++;
        if (reset)
        begin
            model_phase = '0;
            model_sample = '0;
            model_voice = '0;
            voice_source = '0;
        end
        else
        begin
            voice_source = model_sample;
            model_voice = (model_sample > prev_clamp) ? prev_clamp : model_sample;
            model_sample = model_mix(model_phase, pulse_width, wave_ctrl);
            model_phase = model_phase + phase_t'(frequency);
        end
        prev_clamp = {env_level, 4'h0};
        check_value("voice", model_voice, voice);
    endtask

    // level walk, every change one count and spacing fixed after the first step
    task automatic walk_level(input int dir, input int target, input int spacing,
                              input string name);
        int last_level;
        int last_change;
        int limit;
        int count;
        bit stepped;
        last_level = env_level;
        last_change = 0;
        stepped = 1'b0;
        count = 0;
        limit = 256 * spacing + 100;
        while (env_level != target && count < limit)
        begin
            advance();
            count++;
            if (env_level != last_level)
            begin
                check_value("env_level", last_level + dir, env_level);
                if (stepped)
                    check_value({name, "_spacing"}, spacing, cycle - last_change);
                stepped = 1'b1;
                last_change = cycle;
                last_level = env_level;
            end
        end
        if (env_level != target)
            report_failure($sformatf("%s did not reach level %0d within %0d cycles",
                                     name, target, limit));
    endtask

    // held level under changing waveforms
    task automatic hold_level(input int cycles, input int level, input logic gate,
                              input bit clamp_checks);
        sample_t clamp;
        clamp = sample_t'(level * 16);
        for (int i = 0; i < cycles; i++)
        begin
            if (i % 16 == 0)
                randomize_wave(gate);
            advance();
            check_value("env_level", level, env_level);
            if (clamp_checks)
            begin
                if (voice > clamp)
                    report_failure("voice rose above the envelope clamp");
                if (voice_source < clamp)
                    check_value("voice", voice_source, voice);
            end
        end
    endtask

    initial
    begin
        reset = 1'b1;
        frequency = '0;
        pulse_width = '0;
        wave_ctrl = '0;
        adsr = '0;
        cycle = 0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        prev_clamp = '0;
        repeat (3) advance();
        reset = 1'b0;

        // gate low keeps the envelope silent
        hold_level(200, 0, 1'b0, 1'b0);

        // attack up to the peak, sustain 15 parks it there
        atk_nib = rand_range(0, 2);
        dcy_nib = rand_range(0, 2);
        rel_nib = rand_range(0, 2);
        sus_nib = rand_range(3, 12);
        adsr.attack = rate_index_t'(atk_nib);
        adsr.decay = rate_index_t'(dcy_nib);
        adsr.release_rate = rate_index_t'(rel_nib);
        adsr.sustain = 4'hf;
        wave_ctrl.gate = 1'b1;
        walk_level(1, 255, attack_table[atk_nib] + 1, "attack");

        // full level, exact voice on every cycle
        hold_level(600, 255, 1'b1, 1'b0);

        // lower sustain sends the envelope back into decay
        adsr.sustain = rate_index_t'(sus_nib);
        walk_level(-1, sus_nib * 16 + 15, dec_rel_table[dcy_nib] + 1, "decay");
        hold_level(400, sus_nib * 16 + 15, 1'b1, 1'b1);

        // release to zero then idle
        wave_ctrl.gate = 1'b0;
        walk_level(-1, 0, dec_rel_table[rel_nib] + 1, "release");
        hold_level(200, 0, 1'b0, 1'b0);

        // retrigger, first attack step
        wave_ctrl.gate = 1'b1;
        waited = 0;
        while (env_level != 1 && waited < 2 * (attack_table[atk_nib] + 1) + 10)
        begin
            advance();
            waited++;
        end
        if (env_level != 1)
            report_failure("envelope did not restart after the gate rose again");

        $display("value errors %0d, other errors %0d, assertion failures %0d, checks %0d",
                 value_errors, other_errors, u_dut.u_props.assert_failures, checks);
        if (value_errors + other_errors + u_dut.u_props.assert_failures == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized from the planned test lengths
    initial
    begin
        #((PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
        $display("timeout: the run did not finish within %0d cycles",
                 PLANNED_CYCLES + MARGIN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/voice_props.sv
// ******************************
// voice output assertions
// bound into sid_voice
// ******************************

`timescale 1ns/1ns

`include "voice_cfg.svh"

`default_nettype none

module voice_props (
    input logic             clk_1MHz,
    input logic             reset,
    input osc_pkg::sample_t voice,
    input env_pkg::level_t  env_level
);

    import osc_pkg::*;
    import env_pkg::*;

    // assertion failures so far
    int assert_failures = 0;

    // the counter only ever moves by one step
    // compared one bit wider so a wrap between 0 and 255 is a jump
    level_moves_by_one: assert property (@(posedge clk_1MHz) disable iff (reset)
        (env_level == $past(env_level)) ||
        ({1'b0, env_level} == {1'b0, $past(env_level)} + 1'b1) ||
        ({1'b0, env_level} == {1'b0, $past(env_level)} - 1'b1))
    else
    begin
        $error("env_level moved by more than one step");
        assert_failures++;
    end

    // output stays under the clamp of the previous level
    voice_under_clamp: assert property (@(posedge clk_1MHz) disable iff (reset)
        voice <= {$past(env_level), {(`VOICE_SAMPLE_W - `VOICE_LEVEL_W){1'b0}}})
    else
    begin
        $error("voice above the previous envelope level times 16");
        assert_failures++;
    end

    // both outputs come out of reset at zero
    zero_after_reset: assert property (@(posedge clk_1MHz)
        $fell(reset) |-> (voice == '0 && env_level == '0))
    else
    begin
        $error("voice or env_level not zero after reset");
        assert_failures++;
    end

endmodule

bind sid_voice voice_props u_props (
    .clk_1MHz  (clk_1MHz),
    .reset     (reset),
    .voice     (voice),
    .env_level (env_level)
);

`default_nettype wire

//--- source/env_pkg.sv
// ******************************
// envelope types
// state enum, level, rates, adsr
// ******************************

`include "voice_cfg.svh"

`default_nettype none

package env_pkg;

    // envelope level driving the dca
    typedef logic [`VOICE_LEVEL_W-1:0] level_t;

    // one 4-bit rate or sustain setting
    typedef logic [`VOICE_SUS_W-1:0] rate_index_t;

    // reload value of the rate divider
    typedef logic [`VOICE_RATE_W-1:0] rate_t;

    // the four envelope nibbles
    // attack sits in the top nibble
    typedef struct packed {
        rate_index_t attack;
        rate_index_t decay;
        rate_index_t sustain;
        rate_index_t release_rate;
    } adsr_t;

    // envelope phases
    // setup states are folded into the counting states
    typedef enum logic [2:0] {
        env_idle    = 3'd0,
        env_attack  = 3'd1,
        env_decay   = 3'd2,
        env_sustain = 3'd3,
        env_release = 3'd4
    } env_state_e;

endpackage

`default_nettype wire

//--- source/env_rate_timer.sv
// ******************************
// envelope rate tables
// reloading step divider
// ******************************

`timescale 1ns/1ns

`default_nettype none

module env_rate_timer (
    input  logic                clk_1MHz,
    input  logic                reset,
    input  env_pkg::adsr_t      adsr,
    input  env_pkg::env_state_e env_phase,
    output logic                step
);

    import env_pkg::*;

    env_state_e  last_phase;
    rate_index_t dec_rel_index;
    rate_t       attack_reload;
    rate_t       dec_rel_reload;
    rate_t       reload;
    rate_t       count;
    logic        restart;

    // release nibble in release and the decay nibble in every other phase
    assign dec_rel_index = (env_phase == env_release) ? adsr.release_rate : adsr.decay;

    // attack reload is about the attack time in us over 254 steps
    always_comb
    begin
        case (adsr.attack)
            4'd0:    attack_reload = 16'd8;
            4'd1:    attack_reload = 16'd31;
            4'd2:    attack_reload = 16'd63;
            4'd3:    attack_reload = 16'd94;
            4'd4:    attack_reload = 16'd150;
            4'd5:    attack_reload = 16'd220;
            4'd6:    attack_reload = 16'd268;
            4'd7:    attack_reload = 16'd315;
            4'd8:    attack_reload = 16'd394;
            4'd9:    attack_reload = 16'd984;
            4'd10:   attack_reload = 16'd1968;
            4'd11:   attack_reload = 16'd3150;
            4'd12:   attack_reload = 16'd3937;
            4'd13:   attack_reload = 16'd11811;
            4'd14:   attack_reload = 16'd19685;
            default: attack_reload = 16'd31496;
        endcase
    end

    // shared decay and release table with reloads near the time in us over 1632
    always_comb
    begin
        case (dec_rel_index)
            4'd0:    dec_rel_reload = 16'd3;
            4'd1:    dec_rel_reload = 16'd15;
            4'd2:    dec_rel_reload = 16'd29;
            4'd3:    dec_rel_reload = 16'd44;
            4'd4:    dec_rel_reload = 16'd70;
            4'd5:    dec_rel_reload = 16'd103;
            4'd6:    dec_rel_reload = 16'd125;
            4'd7:    dec_rel_reload = 16'd147;
            4'd8:    dec_rel_reload = 16'd184;
            4'd9:    dec_rel_reload = 16'd459;
            4'd10:   dec_rel_reload = 16'd919;
            4'd11:   dec_rel_reload = 16'd1471;
            4'd12:   dec_rel_reload = 16'd1838;
            4'd13:   dec_rel_reload = 16'd5515;
            4'd14:   dec_rel_reload = 16'd9191;
            default: dec_rel_reload = 16'd14706;
        endcase
    end

    // idle and attack use the attack rate
    assign reload = (env_phase == env_idle || env_phase == env_attack) ?
                    attack_reload : dec_rel_reload;

    // any phase change restarts the divider
    assign restart = (env_phase != last_phase);

    // tick on the zero count but not in a restart cycle
    assign step = (count == '0) && !restart;

    // down counter with reload + 1 cycles between ticks
    always_ff @(posedge clk_1MHz)
    begin
        if (reset)
        begin
            last_phase <= env_idle;
            // starts far from zero so no tick follows reset
            count      <= '1;
        end
        else
        begin
            last_phase <= env_phase;
            if (restart || count == '0)
                count <= reload;
            else
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/env_state_machine.sv
// ******************************
// adsr phase sequencer
// level compares and count controls
// ******************************

`timescale 1ns/1ns

`include "voice_cfg.svh"

`default_nettype none

module env_state_machine (
    input  logic                 clk_1MHz,
    input  logic                 reset,
    input  logic                 gate,
    input  env_pkg::rate_index_t sustain,
    input  env_pkg::level_t      level,
    output env_pkg::env_state_e  env_phase,
    output logic                 count_en,
    output logic                 count_up,
    output logic                 level_clear
);

    import env_pkg::*;

    env_state_e next_phase;

    logic at_peak;
    logic at_zero;
    logic at_sustain;

    // all level comparisons live here
    assign at_peak    = (level == '1);
    assign at_zero    = (level == '0);
    // upper nibble of the counter against the sustain register
    assign at_sustain = (level[`VOICE_LEVEL_W-1 -: `VOICE_SUS_W] == sustain);

    always_ff @(posedge clk_1MHz)
    begin
        if (reset)
        begin
            env_phase <= env_idle;
        end
        else
        begin
            env_phase <= next_phase;
        end
    end

    // next phase from the gate and this cycle's level
    always_comb
    begin
        next_phase = env_phase;
        case (env_phase)
            env_idle:
            begin
                if (gate)
                    next_phase = env_attack;
            end
            env_attack:
            begin
                // reaching the peak wins over a gate drop
                if (at_peak)
                    next_phase = env_decay;
                else if (!gate)
                    next_phase = env_release;
            end
            env_decay:
            begin
                if (at_sustain)
                    next_phase = env_sustain;
                else if (!gate)
                    next_phase = env_release;
            end
            env_sustain:
            begin
                // a lowered sustain setting sends us back to decay
                if (!gate)
                    next_phase = env_release;
                else if (!at_sustain)
                    next_phase = env_decay;
            end
            env_release:
            begin
                // retrigger goes through idle to clear the level
                if (at_zero || gate)
                    next_phase = env_idle;
            end
            default:
            begin
                next_phase = env_idle;
            end
        endcase
    end

    // counter controls per phase
    // count_en stops at the ends so the level never wraps
    always_comb
    begin
        count_en    = 1'b0;
        count_up    = 1'b0;
        level_clear = 1'b0;
        case (env_phase)
            env_idle:
            begin
                level_clear = 1'b1;
            end
            env_attack:
            begin
                count_en = !at_peak;
                count_up = 1'b1;
            end
            env_decay, env_release:
            begin
                count_en = !at_zero;
            end
            default:
            begin
                // sustain holds
                count_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/envelope_dca.sv
// ******************************
// level counter and output clamp
// ******************************

`timescale 1ns/1ns

`include "voice_cfg.svh"

`default_nettype none

module envelope_dca (
    input  logic             clk_1MHz,
    input  logic             reset,
    input  logic             step,
    input  logic             count_en,
    input  logic             count_up,
    input  logic             level_clear,
    input  osc_pkg::sample_t wave_sample,
    output env_pkg::level_t  level,
    output osc_pkg::sample_t voice
);

    import osc_pkg::*;
    import env_pkg::*;

    sample_t clamp;

    // level times 16 on the sample scale
    assign clamp = {level, {(`VOICE_SAMPLE_W - `VOICE_LEVEL_W){1'b0}}};

    // 8-bit up/down counter
    // clear wins, otherwise one count per enabled step
    always_ff @(posedge clk_1MHz)
    begin
        if (reset || level_clear)
            level <= '0;
        else if (step && count_en)
        begin
            if (count_up)
                level <= level + 1'b1;
            else
                level <= level - 1'b1;
        end
    end

    // output is the waveform limited to the envelope
    always_ff @(posedge clk_1MHz)
    begin
        if (reset)
            voice <= '0;
        else
            voice <= (wave_sample > clamp) ? clamp : wave_sample;
    end

endmodule

`default_nettype wire

//--- source/osc_pkg.sv
// ******************************
// oscillator types
// phase, frequency, sample, controls
// ******************************

`include "voice_cfg.svh"

`default_nettype none

package osc_pkg;

    // accumulator value
    typedef logic [`VOICE_PHASE_W-1:0] phase_t;

    // pitch increment per clock
    typedef logic [`VOICE_FREQ_W-1:0] freq_t;

    // one waveform sample
    typedef logic [`VOICE_SAMPLE_W-1:0] sample_t;

    // voice control bits
    // gate starts the envelope, the enables pick the waveforms
    typedef struct packed {
        logic gate;
        logic triangle_en;
        logic sawtooth_en;
        logic pulse_en;
    } wave_ctrl_t;

endpackage

`default_nettype wire

//--- source/phase_accumulator.sv
// ******************************
// 24-bit phase accumulator
// ******************************

`timescale 1ns/1ns

`default_nettype none

module phase_accumulator (
    input  logic            clk_1MHz,
    input  logic            reset,
    input  osc_pkg::freq_t  frequency,
    output osc_pkg::phase_t phase
);

    import osc_pkg::*;

    // frequency word zero extended to the accumulator width
    phase_t increment;

    // only the lower 16 bits are programmable
    // the upper bits just carry the wrap
    assign increment = phase_t'(frequency);

    // free running accumulator
    // wraps modulo 2^24, the msb sets the pitch period
    always_ff @(posedge clk_1MHz)
    begin
        if (reset)
        begin
            phase <= '0;
        end
        else
        begin
            // plain add, no carry out kept
            phase <= phase + increment;
        end
    end

endmodule

`default_nettype wire

//--- source/sid_voice.sv
// ******************************
// one synth voice
// oscillator into envelope dca
// ******************************

`timescale 1ns/1ns

`default_nettype none

module sid_voice (
    input  logic                clk_1MHz,
    input  logic                reset,
    input  osc_pkg::freq_t      frequency,
    input  osc_pkg::sample_t    pulse_width,
    input  osc_pkg::wave_ctrl_t wave_ctrl,
    input  env_pkg::adsr_t      adsr,
    output osc_pkg::sample_t    voice,
    output env_pkg::level_t     env_level
);

    import osc_pkg::*;
    import env_pkg::*;

    phase_t     phase;
    sample_t    wave_sample;
    env_state_e env_phase;
    logic       count_en;
    logic       count_up;
    logic       level_clear;
    logic       step;

    // oscillator path
    phase_accumulator u_phase (
        .clk_1MHz  (clk_1MHz),
        .reset     (reset),
        .frequency (frequency),
        .phase     (phase)
    );

    waveform_mux u_wave (
        .clk_1MHz    (clk_1MHz),
        .reset       (reset),
        .phase       (phase),
        .pulse_width (pulse_width),
        .wave_ctrl   (wave_ctrl),
        .wave_sample (wave_sample)
    );

    // envelope path
    env_state_machine u_fsm (
        .clk_1MHz    (clk_1MHz),
        .reset       (reset),
        .gate        (wave_ctrl.gate),
        .sustain     (adsr.sustain),
        .level       (env_level),
        .env_phase   (env_phase),
        .count_en    (count_en),
        .count_up    (count_up),
        .level_clear (level_clear)
    );

    env_rate_timer u_timer (
        .clk_1MHz  (clk_1MHz),
        .reset     (reset),
        .adsr      (adsr),
        .env_phase (env_phase),
        .step      (step)
    );

    // the counter output doubles as the env_level port
    envelope_dca u_dca (
        .clk_1MHz    (clk_1MHz),
        .reset       (reset),
        .step        (step),
        .count_en    (count_en),
        .count_up    (count_up),
        .level_clear (level_clear),
        .wave_sample (wave_sample),
        .level       (env_level),
        .voice       (voice)
    );

endmodule

`default_nettype wire

//--- source/voice_cfg.svh
// ******************************
// width macros for the synth voice
// oscillator, envelope and divider
// ******************************

`ifndef VOICE_CFG_SVH
`define VOICE_CFG_SVH

// phase accumulator width
`define VOICE_PHASE_W 24

// frequency increment added every clock
`define VOICE_FREQ_W 16

// waveform and output sample width
`define VOICE_SAMPLE_W 12

// envelope level counter width
`define VOICE_LEVEL_W 8

// reload width of the envelope rate divider
`define VOICE_RATE_W 16

// nibble width of the rate registers
// also the number of upper level bits compared against sustain
`define VOICE_SUS_W 4

`endif

//--- source/waveform_mux.sv
// ******************************
// sawtooth, triangle and pulse
// registered waveform mix
// ******************************

`timescale 1ns/1ns

`include "voice_cfg.svh"

`default_nettype none

module waveform_mux (
    input  logic                clk_1MHz,
    input  logic                reset,
    input  osc_pkg::phase_t     phase,
    input  osc_pkg::sample_t    pulse_width,
    input  osc_pkg::wave_ctrl_t wave_ctrl,
    output osc_pkg::sample_t    wave_sample
);

    import osc_pkg::*;

    sample_t sawtooth;
    sample_t tri_fold;
    sample_t triangle;
    sample_t pulse;
    sample_t mixed;

    // ramp is the top 12 accumulator bits
    assign sawtooth = phase[`VOICE_PHASE_W-1 -: `VOICE_SAMPLE_W];

    // msb inverts the next 12 bits
    // this folds the ramp into a rising and falling half
    assign tri_fold = phase[`VOICE_PHASE_W-2 -: `VOICE_SAMPLE_W]
                      ^ {`VOICE_SAMPLE_W{phase[`VOICE_PHASE_W-1]}};

    // flip the folded value so the triangle starts at full scale
    assign triangle = {`VOICE_SAMPLE_W{1'b1}} - tri_fold;

    // comparator output drives every sample bit
    assign pulse = (sawtooth >= pulse_width) ? {`VOICE_SAMPLE_W{1'b1}} : '0;

    // enabled waveforms are ANDed in then ORed together
    // nothing enabled gives silence
    always_comb
    begin
        mixed = '0;
        if (wave_ctrl.sawtooth_en)
        begin
            mixed = mixed | sawtooth;
        end
        if (wave_ctrl.triangle_en)
        begin
            mixed = mixed | triangle;
        end
        if (wave_ctrl.pulse_en)
        begin
            mixed = mixed | pulse;
        end
    end

    // one register stage after the phase
    always_ff @(posedge clk_1MHz)
    begin
        if (reset)
        begin
            wave_sample <= '0;
        end
        else
        begin
            wave_sample <= mixed;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/osc_pkg.sv
source/env_pkg.sv
source/phase_accumulator.sv
source/waveform_mux.sv
source/env_state_machine.sv
source/env_rate_timer.sv
source/envelope_dca.sv
source/sid_voice.sv
sim/clock_gen.sv
sim/voice_props.sv
sim/tb_sid_voice.sv
